// ==== hdl/conv_pkg.sv ====
`default_nettype none

package conv_pkg;

  ////////////////////////////////////////
  // sizes
  ////////////////////////////////////////

  localparam int WIN       = 5;
  localparam int MAX_IMG   = 256;
  localparam int IMG_W     = 9;
  localparam int PTR_W     = $clog2(MAX_IMG);
  localparam int NUM_COEFF = WIN * WIN;
  localparam int SHIFT_W   = 4;
  localparam int LANES     = 4;
  localparam int PIX_MAX   = 255;

  // unsigned pixel widened by one bit times an 8-bit coefficient.
  localparam int PROD_W    = 17;
  localparam int ROW_W     = PROD_W + 3;
  localparam int SUM_W     = ROW_W + 3;

  // word index of each register, taken from adr[5:2].
  localparam logic [3:0] ADDR_CTRL   = 4'h0;
  localparam logic [3:0] ADDR_COEFF0 = 4'h1;
  localparam logic [3:0] ADDR_COEFF1 = 4'h2;
  localparam logic [3:0] ADDR_COEFF2 = 4'h3;
  localparam logic [3:0] ADDR_COEFF3 = 4'h4;
  localparam logic [3:0] ADDR_COEFF4 = 4'h5;
  localparam logic [3:0] ADDR_COEFF5 = 4'h6;
  localparam logic [3:0] ADDR_COEFF6 = 4'h7;
  localparam logic [3:0] ADDR_STATUS = 4'h8;

  ////////////////////////////////////////
  // data types
  ////////////////////////////////////////

  typedef logic [7:0]        pixel_t;
  typedef logic signed [7:0] coeff_t;
  typedef logic [IMG_W-1:0]  img_size_t;

  // px[0][0] is the top-left pixel.
  typedef struct packed {
    pixel_t [0:WIN-1][0:WIN-1] px;
  } window_t;

  typedef struct packed {
    img_size_t                img_size;
    logic [SHIFT_W-1:0]       shift;
    logic                     enable;
    coeff_t [NUM_COEFF-1:0]   coeffs;
  } cfg_t;

  ////////////////////////////////////////
  // wishbone
  ////////////////////////////////////////

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [5:0]  adr;
    logic [31:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  // same bus word seen as ctrl or as four coefficients.
  typedef union packed {
    struct packed {
      logic [31-IMG_W-SHIFT_W-1:0] rsvd;
      logic [SHIFT_W-1:0]          shift;
      img_size_t                   img_size;
      logic                        enable;
    } ctrl;
    coeff_t [LANES-1:0] coeff;
  } csr_word_u;

endpackage

`default_nettype wire

// ==== hdl/conv_csr_wb.sv ====
`default_nettype none

module conv_csr_wb import conv_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  wb_req_t wb_req_i,
  output wb_rsp_t wb_rsp_o,
  input  logic    frame_done_i,
  output cfg_t    cfg_o
);

  cfg_t        cfg_q;
  logic [15:0] frame_cnt_q;
  logic        ack_q;
  logic [31:0] rdat_q;
  logic        req;
  logic        wr_en;
  logic [3:0]  word;
  logic        is_coeff;
  logic [2:0]  coeff_sel;
  csr_word_u   wr_word;
  csr_word_u   rd_word;

  // coefficient slot carried by one lane of a coeff word.
  function automatic int slot(logic [2:0] sel, int lane);
    return int'(sel) * LANES + lane;
  endfunction

  // no new request while ack is out, so ack lasts one cycle.
  assign req       = wb_req_i.cyc && wb_req_i.stb && !ack_q;
  assign wr_en     = req && wb_req_i.we;
  assign word      = wb_req_i.adr[5:2];
  assign is_coeff  = (word >= ADDR_COEFF0) && (word <= ADDR_COEFF6);
  assign coeff_sel = 3'(word - ADDR_COEFF0);
  assign wr_word   = wb_req_i.dat;

  always_comb begin
    rd_word = '0;
    if (word == ADDR_CTRL) begin
      rd_word.ctrl.enable   = cfg_q.enable;
      rd_word.ctrl.img_size = cfg_q.img_size;
      rd_word.ctrl.shift    = cfg_q.shift;
    end else if (is_coeff) begin
      for (int i = 0; i < LANES; i++) begin
        if (slot(coeff_sel, i) < NUM_COEFF) begin
          rd_word.coeff[i] = cfg_q.coeffs[slot(coeff_sel, i)];
        end
      end
    end else if (word == ADDR_STATUS) begin
      rd_word = {16'h0000, frame_cnt_q};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack_q       <= 1'b0;
      cfg_q       <= '0;
      frame_cnt_q <= '0;
    end else begin
      ack_q <= req;
      if (wr_en && word == ADDR_CTRL) begin
        cfg_q.enable   <= wr_word.ctrl.enable;
        cfg_q.img_size <= wr_word.ctrl.img_size;
        cfg_q.shift    <= wr_word.ctrl.shift;
      end
      if (wr_en && is_coeff) begin
        for (int i = 0; i < LANES; i++) begin
          if (slot(coeff_sel, i) < NUM_COEFF) begin
            cfg_q.coeffs[slot(coeff_sel, i)] <= wr_word.coeff[i];
          end
        end
      end
      // a write to status clears the frame count.
      if (wr_en && word == ADDR_STATUS) begin
        frame_cnt_q <= '0;
      end else if (frame_done_i) begin
        frame_cnt_q <= frame_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      rdat_q <= rd_word;
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rdat_q;
  assign cfg_o        = cfg_q;

endmodule

`default_nettype wire

// ==== hdl/line_buffer.sv ====
`default_nettype none

module line_buffer import conv_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             shift_i,
  input  pixel_t           pix_i,
  input  img_size_t        img_size_i,
  output pixel_t [WIN-1:0] taps_o
);

  localparam int ROWS = WIN - 1;

  pixel_t           mem [ROWS][MAX_IMG];
  pixel_t           row_in [ROWS];
  pixel_t [WIN-1:0] taps_q;
  logic [PTR_W-1:0] ptr_q;
  logic             ptr_wrap;

  // one row back per memory, so wrap at the frame side.
  assign ptr_wrap = (IMG_W'(ptr_q) + 1'b1) >= img_size_i;

  // each memory is fed by the output of the newer one.
  always_comb begin
    row_in[ROWS-1] = pix_i;
    for (int r = 0; r < ROWS - 1; r++) begin
      row_in[r] = mem[r+1][ptr_q];
    end
  end

  always_ff @(posedge clk) begin
    if (shift_i) begin
      taps_q[WIN-1] <= pix_i;
      for (int r = 0; r < ROWS; r++) begin
        taps_q[r]     <= mem[r][ptr_q];
        mem[r][ptr_q] <= row_in[r];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr_q <= '0;
    end else if (shift_i) begin
      ptr_q <= ptr_wrap ? '0 : ptr_q + 1'b1;
    end
  end

  // tap 0 is the oldest row.
  assign taps_o = taps_q;

endmodule

`default_nettype wire

// ==== hdl/window_5x5.sv ====
`default_nettype none

module window_5x5 import conv_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  cfg_t    cfg_i,
  input  pixel_t  pix_i,
  input  logic    pix_valid_i,
  output logic    shift_o,
  output pixel_t  line_pix_o,
  output window_t win_o,
  output logic    win_valid_o,
  output logic    frame_done_o,
  output logic    busy_o
);

  typedef enum logic [1:0] {IDLE, FILL, RUN, FLUSH} state_t;

  state_t                      state_q;
  logic [IMG_W:0]              beat_cnt_q;
  img_size_t                   n_last;
  img_size_t                   in_row_q;
  img_size_t                   in_col_q;
  img_size_t                   out_row_q;
  img_size_t                   out_col_q;
  img_size_t                   cen_row_q;
  img_size_t                   cen_col_q;
  logic                        beat_last;
  logic                        in_last;
  logic                        advance;
  logic                        produce;
  logic                        win_valid_q;
  logic                        frame_done_q;
  pixel_t [WIN-1:0]            taps;
  pixel_t [WIN-1:0][WIN-2:0]   hist_q;
  pixel_t [WIN-1:0][WIN-1:0]   view;
  logic [WIN-1:0]              row_ok;
  logic [WIN-1:0]              col_ok;

  function automatic logic in_frame(img_size_t pos, int d, img_size_t n);
    int p;
    p = int'(pos) + d - WIN / 2;
    return (p >= 0) && (p < int'(n));
  endfunction

  function automatic logic [2*IMG_W-1:0] raster_next(img_size_t row, img_size_t col,
                                                     img_size_t last);
    if (col != last) begin
      return {row, img_size_t'(col + 1'b1)};
    end
    if (row != last) begin
      return {img_size_t'(row + 1'b1), img_size_t'(0)};
    end
    return '0;
  endfunction

  assign n_last     = cfg_i.img_size - 1'b1;
  // fill and flush both last 2n+2 beats.
  assign beat_last  = beat_cnt_q == {cfg_i.img_size, 1'b1};
  assign in_last    = (in_row_q == n_last) && (in_col_q == n_last);
  assign advance    = (state_q == FLUSH) || (pix_valid_i && cfg_i.enable);
  assign produce    = advance && (state_q == RUN || state_q == FLUSH);
  assign shift_o    = advance;
  assign line_pix_o = (state_q == FLUSH) ? '0 : pix_i;

  line_buffer line_buffer_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .shift_i    (shift_o),
    .pix_i      (line_pix_o),
    .img_size_i (cfg_i.img_size),
    .taps_o     (taps)
  );

  ////////////////////////////////////////
  // frame state machine
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q      <= IDLE;
      beat_cnt_q   <= '0;
      win_valid_q  <= 1'b0;
      frame_done_q <= 1'b0;
    end else begin
      win_valid_q  <= produce;
      frame_done_q <= 1'b0;
      if (advance) begin
        if (state_q != RUN) begin
          beat_cnt_q <= beat_last ? '0 : beat_cnt_q + 1'b1;
        end
        case (state_q)
          IDLE: state_q <= FILL;
          FILL: begin
            if (beat_last) begin
              state_q <= RUN;
            end
          end
          RUN: begin
            if (in_last) begin
              state_q <= FLUSH;
            end
          end
          FLUSH: begin
            if (beat_last) begin
              state_q      <= IDLE;
              frame_done_q <= 1'b1;
            end
          end
          default: state_q <= IDLE;
        endcase
      end
    end
  end

  // input position and centre position of the next window.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      {in_row_q, in_col_q}   <= '0;
      {out_row_q, out_col_q} <= '0;
      {cen_row_q, cen_col_q} <= '0;
    end else begin
      if (advance && state_q != FLUSH) begin
        {in_row_q, in_col_q} <= raster_next(in_row_q, in_col_q, n_last);
      end
      if (produce) begin
        {cen_row_q, cen_col_q} <= {out_row_q, out_col_q};
        {out_row_q, out_col_q} <= raster_next(out_row_q, out_col_q, n_last);
      end
    end
  end

  ////////////////////////////////////////
  // window and padding
  ////////////////////////////////////////

  // the tap register is the newest column of each row.
  always_ff @(posedge clk) begin
    if (advance) begin
      for (int r = 0; r < WIN; r++) begin
        hist_q[r] <= {taps[r], hist_q[r][WIN-2:1]};
      end
    end
  end

  always_comb begin
    for (int d = 0; d < WIN; d++) begin
      view[d]   = {taps[d], hist_q[d]};
      row_ok[d] = in_frame(cen_row_q, d, cfg_i.img_size);
      col_ok[d] = in_frame(cen_col_q, d, cfg_i.img_size);
    end
    for (int r = 0; r < WIN; r++) begin
      for (int c = 0; c < WIN; c++) begin
        win_o.px[r][c] = (row_ok[r] && col_ok[c]) ? view[r][c] : '0;
      end
    end
  end

  assign win_valid_o  = win_valid_q;
  assign frame_done_o = frame_done_q;
  assign busy_o       = (state_q != IDLE) || win_valid_q;

endmodule

`default_nettype wire

// ==== hdl/conv_mac.sv ====
`default_nettype none

module conv_mac import conv_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  window_t                win_i,
  input  logic                   win_valid_i,
  input  coeff_t [NUM_COEFF-1:0] coeffs_i,
  input  logic [SHIFT_W-1:0]     shift_i,
  output pixel_t                 res_o,
  output logic                   res_valid_o
);

  logic signed [ROW_W-1:0] row_sum [WIN];
  logic signed [ROW_W-1:0] row_q [WIN];
  logic                    s1_valid_q;
  logic signed [SUM_W-1:0] total;
  logic signed [SUM_W-1:0] scaled;
  pixel_t                  clamped;
  pixel_t                  res_q;
  logic                    res_valid_q;

  function automatic logic signed [PROD_W-1:0] mul(pixel_t p, coeff_t c);
    return $signed({1'b0, p}) * c;
  endfunction

  ////////////////////////////////////////
  // stage 1 products and row sums
  ////////////////////////////////////////

  always_comb begin
    for (int r = 0; r < WIN; r++) begin
      row_sum[r] = '0;
      for (int c = 0; c < WIN; c++) begin
        row_sum[r] = row_sum[r] + mul(win_i.px[r][c], coeffs_i[r*WIN+c]);
      end
    end
  end

  ////////////////////////////////////////
  // stage 2 total, shift and clamp
  ////////////////////////////////////////

  always_comb begin
    total = '0;
    for (int r = 0; r < WIN; r++) begin
      total = total + row_q[r];
    end
    scaled = total >>> shift_i;
    if (scaled < 0) begin
      clamped = '0;
    end else if (scaled > PIX_MAX) begin
      clamped = pixel_t'(PIX_MAX);
    end else begin
      clamped = scaled[7:0];
    end
  end

  always_ff @(posedge clk) begin
    if (win_valid_i) begin
      row_q <= row_sum;
    end
    if (s1_valid_q) begin
      res_q <= clamped;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid_q  <= 1'b0;
      res_valid_q <= 1'b0;
    end else begin
      s1_valid_q  <= win_valid_i;
      res_valid_q <= s1_valid_q;
    end
  end

  assign res_o       = res_q;
  assign res_valid_o = res_valid_q;

endmodule

`default_nettype wire

// ==== hdl/conv_top.sv ====
`default_nettype none

module conv_top import conv_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  wb_req_t wb_req_i,
  output wb_rsp_t wb_rsp_o,
  input  pixel_t  pix_i,
  input  logic    pix_valid_i,
  output pixel_t  res_o,
  output logic    res_valid_o,
  output logic    busy_o
);

  cfg_t    cfg;
  logic    frame_done;
  window_t win;
  logic    win_valid;

  conv_csr_wb csr_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .wb_req_i     (wb_req_i),
    .wb_rsp_o     (wb_rsp_o),
    .frame_done_i (frame_done),
    .cfg_o        (cfg)
  );

  // line buffer feed stays inside the window generator.
  window_5x5 window_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg_i        (cfg),
    .pix_i        (pix_i),
    .pix_valid_i  (pix_valid_i),
    .shift_o      (),
    .line_pix_o   (),
    .win_o        (win),
    .win_valid_o  (win_valid),
    .frame_done_o (frame_done),
    .busy_o       (busy_o)
  );

  conv_mac mac_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .win_i       (win),
    .win_valid_i (win_valid),
    .coeffs_i    (cfg.coeffs),
    .shift_i     (cfg.shift),
    .res_o       (res_o),
    .res_valid_o (res_valid_o)
  );

endmodule

`default_nettype wire

// ==== verification/conv_checker.sv ====
`default_nettype none

module conv_checker import conv_pkg::*; (
  input logic    clk,
  input logic    rst_n,
  input wb_req_t wb_req_i,
  input wb_rsp_t wb_rsp_o,
  input logic    res_valid_o,
  input logic    busy_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned assert_fails = 0;

  ////////////////////////////////////////
  // wishbone
  ////////////////////////////////////////

  ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    wb_rsp_o.ack |-> (wb_req_i.cyc && wb_req_i.stb))
  else begin
    $error("ack raised outside a bus cycle");
    assert_fails++;
  end

  ack_single: assert property (@(posedge clk) disable iff (!rst_n)
    wb_rsp_o.ack |=> !wb_rsp_o.ack)
  else begin
    $error("ack high in two consecutive cycles");
    assert_fails++;
  end

  // results trail busy by at most the MAC latency.
  res_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid_o |-> (busy_o || $past(busy_o, 1) || $past(busy_o, 2)))
  else begin
    $error("result valid outside a busy frame");
    assert_fails++;
  end

endmodule

bind conv_top conv_checker checker_i (.*);

`default_nettype wire

// ==== verification/conv_tb.sv ====
`default_nettype none

module conv_tb import conv_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int SEED = 51030;
  // frames of side 6, 7, 9 and four of 5, at (n+3)^2*2 each, plus 200 per test.
  localparam int MAX_CYCLES = 2 * (9*9 + 10*10 + 12*12 + 4*8*8) + 5 * 200;

  logic    clk = 1'b0;
  logic    rst_n;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;
  pixel_t  pix;
  logic    pix_valid;
  pixel_t  res;
  logic    res_valid;
  logic    busy;

  pixel_t  img_q[$];
  pixel_t  res_q[$];
  coeff_t  kern [NUM_COEFF];
  int      errors = 0;
  int      checks = 0;
  int      tests = 0;
  int      cycles = 0;

  always #10 clk = ~clk;

  conv_top dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_req_i    (wb_req),
    .wb_rsp_o    (wb_rsp),
    .pix_i       (pix),
    .pix_valid_i (pix_valid),
    .res_o       (res),
    .res_valid_o (res_valid),
    .busy_o      (busy)
  );

  always @(negedge clk) begin
    if (rst_n && res_valid) begin
      res_q.push_back(res);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run exceeded %0d cycles", MAX_CYCLES);
      $display("Regression failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // bus and stimulus tasks
  ////////////////////////////////////////

  task automatic reset_dut();
    @(posedge clk);
    #2;
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
  endtask

  task automatic wb_cycle(input logic we, input logic [3:0] word, input logic [31:0] wdat,
                          output logic [31:0] rdat);
    int wait_cnt;
    @(posedge clk);
    #2;
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: {word, 2'b00}, dat: wdat};
    wait_cnt = 0;
    @(negedge clk);
    while (!wb_rsp.ack && wait_cnt < 16) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (!wb_rsp.ack) begin
      errors++;
      $display("bus error: no ack for register word %0d", word);
    end
    rdat = wb_rsp.dat;
    @(posedge clk);
    #2;
    wb_req = '0;
  endtask

  task automatic wb_write(input logic [3:0] word, input logic [31:0] data);
    logic [31:0] unused;
    wb_cycle(1'b1, word, data, unused);
  endtask

  task automatic wb_read(input logic [3:0] word, output logic [31:0] data);
    wb_cycle(1'b0, word, '0, data);
  endtask

  // four coefficients per word, lowest index in the lowest byte.
  function automatic csr_word_u coeff_word(int k);
    csr_word_u w;
    w = '0;
    for (int i = 0; i < LANES; i++) begin
      if (k * LANES + i < NUM_COEFF) begin
        w.coeff[i] = kern[k * LANES + i];
      end
    end
    return w;
  endfunction

  function automatic csr_word_u ctrl_word(int n, int shift);
    csr_word_u w;
    w = '0;
    w.ctrl.enable   = 1'b1;
    w.ctrl.img_size = img_size_t'(n);
    w.ctrl.shift    = 4'(shift);
    return w;
  endfunction

  task automatic configure(input int n, input int shift);
    for (int k = 0; k < 7; k++) begin
      wb_write(4'(ADDR_COEFF0 + k), coeff_word(k));
    end
    wb_write(ADDR_CTRL, ctrl_word(n, shift));
  endtask

  task automatic make_image(input int n, input int lo, input int hi);
    img_q.delete();
    for (int i = 0; i < n * n; i++) begin
      img_q.push_back(pixel_t'($urandom_range(hi, lo)));
    end
  endtask

  task automatic fill_kernel(input int value, input bit random);
    foreach (kern[k]) begin
      kern[k] = random ? coeff_t'($urandom) : coeff_t'(value);
    end
  endtask

  ////////////////////////////////////////
  // reference model and compares
  ////////////////////////////////////////

  // zero-padded 5x5 correlation, top-left coefficient first.
  function automatic pixel_t ref_pixel(int n, int row, int col, int shift);
    int acc;
    int r;
    int c;
    acc = 0;
    for (int dr = -2; dr <= 2; dr++) begin
      for (int dc = -2; dc <= 2; dc++) begin
        r = row + dr;
        c = col + dc;
        if (r >= 0 && r < n && c >= 0 && c < n) begin
          acc += int'(kern[(dr + 2) * WIN + dc + 2]) * int'(img_q[r * n + c]);
        end
      end
    end
    acc = acc >>> shift;
    if (acc < 0) begin
      acc = 0;
    end else if (acc > 255) begin
      acc = 255;
    end
    return pixel_t'(acc);
  endfunction

  task automatic compare_pixel(input string name, input pixel_t expected, input pixel_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s: expected %0d actual %0d", name, expected, actual);
    end
  endtask

  task automatic compare_word(input string name, input csr_word_u expected,
                              input csr_word_u actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s: expected 'h%08h actual 'h%08h", name, expected, actual);
    end
  endtask

  task automatic compare_count(input string name, input int expected, input int actual);
    checks++;
    if (actual != expected) begin
      errors++;
      $display("mismatch %s result count: expected %0d actual %0d", name, expected, actual);
    end
  endtask

  task automatic run_frame(input string name, input int n, input int shift, input bit gaps);
    configure(n, shift);
    res_q.delete();
    foreach (img_q[i]) begin
      @(posedge clk);
      #2;
      while (gaps && $urandom_range(3) == 0) begin
        pix_valid = 1'b0;
        @(posedge clk);
        #2;
      end
      pix       = img_q[i];
      pix_valid = 1'b1;
    end
    @(posedge clk);
    #2;
    pix_valid = 1'b0;
    while (busy) begin
      @(posedge clk);
      #2;
    end
    // last results trail busy by the MAC latency.
    repeat (4) @(posedge clk);
    compare_count(name, n * n, res_q.size());
    for (int i = 0; i < n * n && i < res_q.size(); i++) begin
      compare_pixel($sformatf("%s pixel %0d", name, i),
                    ref_pixel(n, i / n, i % n, shift), res_q[i]);
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests++;
    $display("test %s: %0d errors", name, errors - errors_before);
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic test_registers();
    int          start;
    logic [31:0] rdat;
    start = errors;
    reset_dut();
    wb_read(ADDR_STATUS, rdat);
    compare_word("status after reset", '0, rdat);
    fill_kernel(0, 1'b1);
    configure(37, 9);
    wb_read(ADDR_CTRL, rdat);
    compare_word("ctrl readback", ctrl_word(37, 9), rdat);
    for (int k = 0; k < 7; k++) begin
      wb_read(4'(ADDR_COEFF0 + k), rdat);
      compare_word($sformatf("coeff word %0d", k), coeff_word(k), rdat);
    end
    end_test("registers", start);
  endtask

  task automatic test_identity();
    int start;
    start = errors;
    reset_dut();
    fill_kernel(0, 1'b0);
    kern[12] = 8'sd1;
    img_q.delete();
    for (int i = 0; i < 36; i++) begin
      img_q.push_back(pixel_t'(i * 7));
    end
    run_frame("identity", 6, 0, 1'b0);
    end_test("identity", start);
  endtask

  task automatic test_padding();
    int start;
    start = errors;
    reset_dut();
    fill_kernel(1, 1'b0);
    // dark pixels keep the 25-tap sum below the clamp.
    make_image(7, 0, 10);
    run_frame("ones 7x7", 7, 0, 1'b0);
    fill_kernel(0, 1'b1);
    make_image(9, 0, 255);
    run_frame("random 9x9", 9, 4, 1'b0);
    end_test("padding", start);
  endtask

  task automatic test_clamp();
    int start;
    start = errors;
    reset_dut();
    fill_kernel(-8, 1'b0);
    make_image(5, 0, 255);
    run_frame("clamp low", 5, 0, 1'b0);
    fill_kernel(16, 1'b0);
    make_image(5, 200, 255);
    run_frame("clamp high", 5, 0, 1'b0);
    end_test("clamp", start);
  endtask

  task automatic test_gaps();
    int          start;
    logic [31:0] rdat;
    start = errors;
    reset_dut();
    fill_kernel(0, 1'b1);
    make_image(5, 0, 255);
    run_frame("gaps frame 0", 5, 3, 1'b1);
    make_image(5, 0, 255);
    run_frame("gaps frame 1", 5, 3, 1'b1);
    wb_read(ADDR_STATUS, rdat);
    compare_word("frame count", 32'd2, rdat);
    wb_write(ADDR_STATUS, '0);
    wb_read(ADDR_STATUS, rdat);
    compare_word("frame count cleared", '0, rdat);
    end_test("gaps", start);
  endtask

  initial begin
    rst_n     = 1'b0;
    wb_req    = '0;
    pix       = '0;
    pix_valid = 1'b0;
    void'($urandom(SEED));
    test_registers();
    test_identity();
    test_padding();
    test_clamp();
    test_gaps();
    errors += dut_i.checker_i.assert_fails;
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
hdl/conv_pkg.sv
hdl/conv_csr_wb.sv
hdl/line_buffer.sv
hdl/window_5x5.sv
hdl/conv_mac.sv
hdl/conv_top.sv
verification/conv_checker.sv
verification/conv_tb.sv

// ==== Bender.yml ====
package:
  name: conv5x5

sources:
  - files:
      - hdl/conv_pkg.sv
      - hdl/conv_csr_wb.sv
      - hdl/line_buffer.sv
      - hdl/window_5x5.sv
      - hdl/conv_mac.sv
      - hdl/conv_top.sv
  - target: simulation
    files:
      - verification/conv_checker.sv
      - verification/conv_tb.sv
